// File: logic/fma_defines.svh
/* fma shared parameters */

`ifndef FMA_DEFINES_SVH
`define FMA_DEFINES_SVH

// requesting ports sharing the datapath
`define FMA_PORTS 2

// port tag carried with each request and result
`define FMA_TAG_W 1

// aligned sum field with carry, 48-bit product and room for c and sticky
`define FMA_WIDE_W 76

// single precision exponent bias
`define FMA_BIAS 127

`endif

// File: logic/fma_pkg.sv
/* fma shared types */

`include "fma_defines.svh"

package fma_pkg;

  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] frac;
  } fp32_t;

  typedef struct packed {
    fp32_t                 a;
    fp32_t                 b;
    fp32_t                 c;
    logic [`FMA_TAG_W-1:0] tag;  // set by the arbiter
  } fma_req_t;

  typedef struct packed {
    fp32_t                 result;
    logic [`FMA_TAG_W-1:0] tag;
  } fma_rsp_t;

  // stage 1 to stage 2
  typedef struct packed {
    logic                   valid;
    logic [`FMA_TAG_W-1:0]  tag;
    logic [`FMA_WIDE_W-1:0] prod;    // product, bit 72 weighs 2^exp
    logic [`FMA_WIDE_W-1:0] addend;  // aligned c
    logic                   sub;     // effective subtraction
    logic                   sign_p;
    logic                   sign_c;
    logic signed [9:0]      exp;     // product exponent, or c's minus one when c dominates
    logic                   p_zero;  // product is zero
    logic                   c_far;   // c wholly below the field, sticky only
  } align_t;

  // stage 2 to stage 3
  typedef struct packed {
    logic                  valid;
    logic [`FMA_TAG_W-1:0] tag;
    logic                  sign;
    logic signed [9:0]     exp;   // biased, may be out of range
    logic [23:0]           mant;  // bit 23 is the hidden one
    logic                  guard;
    logic                  round;
    logic                  sticky;
    logic                  zero;  // exact zero sum
  } norm_t;

endpackage

// File: logic/fma_issue_arbiter.sv
/* fma round-robin issue */

`timescale 1ns/100ps
`include "fma_defines.svh"

module fma_issue_arbiter #(
  parameter int n_ports = `FMA_PORTS
) (
  input  logic              clk,
  input  logic              reset,
  input  logic [n_ports-1:0] req_valid,
  input  fma_pkg::fma_req_t req [n_ports],
  output logic [n_ports-1:0] busy,
  output logic              issue_valid,
  output fma_pkg::fma_req_t issue
);
  localparam int PTR_W = (n_ports > 1) ? $clog2(n_ports) : 1;
  localparam int TAG_W = `FMA_TAG_W;

  fma_pkg::fma_req_t slot [n_ports];  // one pending request per port
  logic [n_ports-1:0] full;
  logic [PTR_W-1:0]   ptr;            // first port to look at
  logic               grant_found;
  logic [PTR_W-1:0]   grant;

  // first full slot at or after the pointer
  always_comb begin
    int idx;
    grant_found = 1'b0;
    grant = '0;
    for (int i = 0; i < n_ports; i++) begin
      idx = int'(ptr) + i;
      if (idx >= n_ports) idx = idx - n_ports;  // wrap
      if (!grant_found && full[idx]) begin
        grant_found = 1'b1;
        grant = PTR_W'(idx);
      end
    end
  end

  assign busy = full;

  always_ff @(posedge clk) begin
    for (int p = 0; p < n_ports; p++) begin
      if (req_valid[p] && !full[p]) begin
        slot[p] <= req[p];
        slot[p].tag <= TAG_W'(p);  // requesters leave the tag open
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= '0;
      ptr <= '0;
    end else begin
      for (int p = 0; p < n_ports; p++) begin
        if (grant_found && grant == PTR_W'(p)) full[p] <= 1'b0;  // issued this edge
        else if (req_valid[p]) full[p] <= 1'b1;
      end
      if (grant_found) ptr <= (grant == PTR_W'(n_ports - 1)) ? '0 : grant + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    issue <= slot[grant];
    if (reset) issue_valid <= 1'b0;
    else issue_valid <= grant_found;
  end

endmodule

// File: logic/fma_unpack_align.sv
/* fma stage 1, unpack and align */

`timescale 1ns/100ps
`include "fma_defines.svh"

module fma_unpack_align (
  input  logic              clk,
  input  logic              reset,
  input  logic              issue_valid,
  input  fma_pkg::fma_req_t issue,
  output fma_pkg::align_t   align
);
  localparam int W = `FMA_WIDE_W;
  localparam logic signed [9:0] BIAS = `FMA_BIAS;

  // right shift, bits falling off are or-ed into bit 0
  function automatic logic [W-1:0] shr_sticky(input logic [W-1:0] x, input logic [9:0] s);
    logic [2*W-1:0] t;
    logic [9:0]     n;
    n = (s > 10'(W)) ? 10'(W) : s;  // saturate, all of x goes to sticky
    t = {x, {W{1'b0}}} >> n;
    return {t[2*W-1:W+1], t[W] | (|t[W-1:0])};
  endfunction

  logic [23:0]       ma, mb, mc;
  logic signed [9:0] ea, eb, ec;
  logic signed [9:0] ep;      // product exponent
  logic signed [9:0] d;       // c exponent minus product exponent
  logic              p_zero, c_zero;
  logic              c_dom;   // c sits above the product
  logic              sign_p;
  logic [47:0]       prod;
  logic [9:0]        rp, rc;  // right shifts of product and c
  fma_pkg::align_t   align_d;

  // subnormals count as zero
  assign ma = (issue.a.exp != 8'd0) ? {1'b1, issue.a.frac} : 24'd0;
  assign mb = (issue.b.exp != 8'd0) ? {1'b1, issue.b.frac} : 24'd0;
  assign mc = (issue.c.exp != 8'd0) ? {1'b1, issue.c.frac} : 24'd0;
  assign p_zero = (issue.a.exp == 8'd0) || (issue.b.exp == 8'd0);
  assign c_zero = (issue.c.exp == 8'd0);

  assign ea = $signed({2'b00, issue.a.exp}) - BIAS;
  assign eb = $signed({2'b00, issue.b.exp}) - BIAS;
  assign ec = $signed({2'b00, issue.c.exp}) - BIAS;
  assign ep = ea + eb;
  assign d = ec - ep;

  assign prod = ma * mb;
  assign sign_p = issue.a.sign ^ issue.b.sign;

  // a zero product never pushes c out of the field
  assign c_dom = !c_zero && (p_zero || d > 10'sd1);
  assign rp = c_dom ? 10'(d - 10'sd1) : 10'd0;
  assign rc = c_dom ? 10'd0 : 10'(10'sd1 - d);

  always_comb begin
    align_d.valid = issue_valid;
    align_d.tag = issue.tag;
    align_d.prod = shr_sticky({{(W-74){1'b0}}, prod, 26'd0}, rp);    // product at [73:26]
    align_d.addend = shr_sticky({{(W-74){1'b0}}, mc, 50'd0}, rc);    // c top at bit 73
    align_d.sub = sign_p ^ issue.c.sign;
    align_d.sign_p = sign_p;
    align_d.sign_c = issue.c.sign;
    align_d.exp = c_dom ? ec - 10'sd1 : ep;
    align_d.p_zero = p_zero;
    align_d.c_far = !c_dom && (rc > 10'd73);
  end

  always_ff @(posedge clk) begin
    align <= align_d;
    if (reset) align.valid <= 1'b0;
  end

endmodule

// File: logic/fma_add_norm.sv
/* fma stage 2, add and normalize */

`timescale 1ns/100ps
`include "fma_defines.svh"

module fma_add_norm (
  input  logic            clk,
  input  logic            reset,
  input  fma_pkg::align_t align,
  output fma_pkg::norm_t  norm
);
  localparam int W = `FMA_WIDE_W;
  // field bit 72 weighs 2^exp, the leading one ends up at bit W-1
  localparam logic [9:0] EXP_ADJ = 10'(`FMA_BIAS - 72);

  logic           c_big;    // c magnitude above the product
  logic [W-1:0]   sum;
  logic [W-1:0]   shifted;
  logic [6:0]     pos;      // leading one position
  logic           zero;
  fma_pkg::norm_t norm_d;

  assign c_big = !align.c_far && (align.p_zero || align.addend > align.prod);

  // magnitude add or larger minus smaller
  always_comb begin
    if (!align.sub) sum = align.prod + align.addend;
    else if (c_big) sum = align.addend - align.prod;
    else sum = align.prod - align.addend;
  end

  // leading one search, highest set bit wins
  always_comb begin
    pos = '0;
    for (int i = 0; i < W; i++) begin
      if (sum[i]) pos = 7'(i);
    end
  end

  assign zero = (sum == '0);
  assign shifted = sum << (7'(W - 1) - pos);

  always_comb begin
    norm_d.valid = align.valid;
    norm_d.tag = align.tag;
    if (zero) begin
      norm_d.sign = align.sign_p & align.sign_c;  // -0 only from two negative zeros
      norm_d.exp = '0;
    end else begin
      norm_d.sign = c_big ? align.sign_c : align.sign_p;
      norm_d.exp = align.exp + 10'(pos) + EXP_ADJ;  // biased
    end
    norm_d.mant = shifted[W-1:W-24];
    norm_d.guard = shifted[W-25];
    norm_d.round = shifted[W-26];
    norm_d.sticky = |shifted[W-27:0];
    norm_d.zero = zero;
  end

  always_ff @(posedge clk) begin
    norm <= norm_d;
    if (reset) norm.valid <= 1'b0;
  end

endmodule

// File: logic/fma_round_pack.sv
/* fma stage 3, round and pack */

`timescale 1ns/100ps

module fma_round_pack (
  input  logic              clk,
  input  logic              reset,
  input  fma_pkg::norm_t    norm,
  output logic              rsp_valid,
  output fma_pkg::fma_rsp_t rsp
);
  logic              inc;
  logic [24:0]       mant_r;  // bit 24 is the rounding carry
  logic signed [9:0] exp_r;
  logic [22:0]       frac;
  logic              flush;
  fma_pkg::fma_rsp_t rsp_d;

  // nearest even
  assign inc = norm.guard & (norm.round | norm.sticky | norm.mant[0]);
  assign mant_r = {1'b0, norm.mant} + 25'(inc);

  // carry out renormalizes by one place
  assign exp_r = norm.exp + 10'(mant_r[24]);
  assign frac = mant_r[24] ? mant_r[23:1] : mant_r[22:0];

  // below the normal range goes to signed zero
  assign flush = norm.zero || (exp_r < 10'sd1);

  always_comb begin
    rsp_d.tag = norm.tag;
    rsp_d.result.sign = norm.sign;
    rsp_d.result.exp = flush ? 8'd0 : exp_r[7:0];
    rsp_d.result.frac = flush ? 23'd0 : frac;
  end

  always_ff @(posedge clk) begin
    rsp <= rsp_d;
    if (reset) rsp_valid <= 1'b0;
    else rsp_valid <= norm.valid;
  end

endmodule

// File: logic/fma_top.sv
/* shared fma unit */

`timescale 1ns/100ps
`include "fma_defines.svh"

module fma_top (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [`FMA_PORTS-1:0] req_valid,
  input  fma_pkg::fma_req_t     req [`FMA_PORTS],
  output logic [`FMA_PORTS-1:0] busy,
  output logic                  rsp_valid,
  output fma_pkg::fma_rsp_t     rsp
);
  logic              issue_valid;
  fma_pkg::fma_req_t issue;
  fma_pkg::align_t   align;
  fma_pkg::norm_t    norm;

  fma_issue_arbiter #(
    .n_ports(`FMA_PORTS)
  ) i_arbiter (
    .clk(clk),
    .reset(reset),
    .req_valid(req_valid),
    .req(req),
    .busy(busy),
    .issue_valid(issue_valid),
    .issue(issue)
  );

  fma_unpack_align i_unpack_align (
    .clk(clk),
    .reset(reset),
    .issue_valid(issue_valid),
    .issue(issue),
    .align(align)
  );

  fma_add_norm i_add_norm (
    .clk(clk),
    .reset(reset),
    .align(align),
    .norm(norm)
  );

  fma_round_pack i_round_pack (
    .clk(clk),
    .reset(reset),
    .norm(norm),
    .rsp_valid(rsp_valid),
    .rsp(rsp)
  );

endmodule

// File: testbench/fma_tb.sv
/* fma testbench */

`timescale 1ns/100ps
`include "fma_defines.svh"

module fma_tb;
  logic                  clk;
  logic                  reset;
  logic [`FMA_PORTS-1:0] req_valid;
  fma_pkg::fma_req_t     req [`FMA_PORTS];
  logic [`FMA_PORTS-1:0] busy;
  logic                  rsp_valid;
  fma_pkg::fma_rsp_t     rsp;

  fma_pkg::fp32_t        exp_q [`FMA_PORTS][$];  // expected results per port
  fma_pkg::fp32_t        expd;
  logic [`FMA_TAG_W-1:0] prev_tag;
  int cycle = 0;
  int probe_cycle = 0;
  bit probe_on = 1'b0;   // time the next result
  bit check_alt = 1'b0;  // tags alternate from the port after the last one served
  int val_errs = 0;
  int other_errs = 0;

  fma_top i_fma_top (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // fp32 to double bits with subnormals as zero
  function automatic logic [63:0] widen(input fma_pkg::fp32_t x);
    if (x.exp == 8'd0) return {x.sign, 63'd0};
    return {x.sign, 11'(int'(x.exp) - `FMA_BIAS + 1023), x.frac, 29'd0};
  endfunction

  // a*b+c exact in double then rounded once to fp32
  function automatic fma_pkg::fp32_t fma_ref(input fma_pkg::fp32_t a, b, c);
    real r;
    logic [63:0] d;
    int e;
    logic [24:0] m;
    r = $bitstoreal(widen(a)) * $bitstoreal(widen(b)) + $bitstoreal(widen(c));
    // an exact zero is -0 only when product and c are both negative zero
    if (r == 0.0) return {(a.sign ^ b.sign) & c.sign, 31'd0};
    d = $realtobits(r);
    e = int'(d[62:52]) - 1023 + `FMA_BIAS;
    m = {2'b01, d[51:29]} + 25'(d[28] & ((|d[27:0]) | d[29]));  // nearest even
    if (m[24]) begin
      e = e + 1;
      m = m >> 1;
    end
    if (e < 1) return {d[63], 31'd0};  // underflow to signed zero
    return {d[63], 8'(e), m[22:0]};
  endfunction

  // normal operand with the low 12 fraction bits clear
  function automatic fma_pkg::fp32_t rand_fp();
    fma_pkg::fp32_t x;
    x.sign = 1'($urandom);
    x.exp = 8'(100 + ($urandom % 55));
    x.frac = {11'($urandom), 12'd0};
    return x;
  endfunction

  // negated product cut to 12 bits so the sum keeps only the low bits
  function automatic fma_pkg::fp32_t cancel_of(input fma_pkg::fp32_t a, b);
    logic [63:0] d;
    d = $realtobits($bitstoreal(widen(a)) * $bitstoreal(widen(b)));
    return {~d[63], 8'(int'(d[62:52]) - 1023 + `FMA_BIAS), d[51:41], 12'd0};
  endfunction

  function automatic int outstanding();
    int n;
    n = 0;
    for (int p = 0; p < `FMA_PORTS; p++) n += exp_q[p].size();
    return n;
  endfunction

  task automatic wait_idle(input int p);
    int n;
    n = 0;
    while (busy[p] && n < 50) begin
      @(posedge clk);
      n++;
    end
    if (busy[p]) begin
      other_errs++;
      $display("port %0d stayed busy for %0d cycles", p, n);
    end
  endtask

  task automatic send(input int p, input fma_pkg::fp32_t a, b, c);
    fma_pkg::fma_req_t r;
    wait_idle(p);
    r = '{a: a, b: b, c: c, tag: '0};
    exp_q[p].push_back(fma_ref(a, b, c));
    req[p] <= r;
    req_valid[p] <= 1'b1;
    @(posedge clk);
    req_valid[p] <= 1'b0;
    @(posedge clk);  // busy shows the loaded buffer from here on
  endtask

  task automatic stream(input int p, input int n);
    repeat (n) send(p, rand_fp(), rand_fp(), rand_fp());
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (outstanding() != 0 && n < 200) begin
      @(posedge clk);
      n++;
    end
    if (outstanding() != 0) begin
      other_errs++;
      $display("%0d results never arrived", outstanding());
      for (int p = 0; p < `FMA_PORTS; p++) exp_q[p].delete();
    end
  endtask

  // result checker
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (!reset && rsp_valid) begin
      assert (exp_q[rsp.tag].size() != 0) else begin
        other_errs++;
        $display("result on port %0d with no request outstanding", rsp.tag);
      end
      if (exp_q[rsp.tag].size() != 0) begin
        expd = exp_q[rsp.tag].pop_front();
        assert (rsp.result == expd) else begin
          val_errs++;
          $display("Fail rsp.result expected %h got %h", expd, rsp.result);
        end
      end
      // seen one edge late and the strobe edge is one after the drive
      if (probe_on) begin
        assert (cycle - probe_cycle == 6) else begin
          other_errs++;
          $display("single request took %0d cycles instead of 4", cycle - probe_cycle - 2);
        end
      end
      if (check_alt) begin
        assert (rsp.tag != prev_tag) else begin
          val_errs++;
          $display("Fail rsp.tag expected %h got %h", ~prev_tag, rsp.tag);
        end
      end
      prev_tag = rsp.tag;
    end
  end

  initial begin
    fma_pkg::fp32_t x, y, z;
    void'($urandom(46));
    reset = 1'b1;
    req_valid = '0;
    for (int p = 0; p < `FMA_PORTS; p++) req[p] = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    repeat (5) begin
      @(posedge clk);
      assert (busy == '0 && !rsp_valid) else begin
        val_errs++;
        $display("Fail busy expected 0 got %h, rsp_valid expected 0 got %h", busy, rsp_valid);
      end
    end

    // lone request on port 0
    probe_cycle = cycle;
    probe_on = 1'b1;
    send(0, 32'h40490000, 32'h3FC00000, 32'hBF800000);
    drain();
    probe_on = 1'b0;

    for (int i = 0; i < 300; i++) send(i % 2, rand_fp(), rand_fp(), rand_fp());
    for (int i = 0; i < 100; i++) begin
      x = rand_fp();
      y = rand_fp();
      z = cancel_of(x, y);
      z.frac[12] = z.frac[12] ^ 1'($urandom);  // c sometimes above the product
      send(i % 2, x, y, z);
    end
    drain();

    // ties of half and one and a half ulp against a 1.0 multiplier
    send(0, 32'h41123000, 32'h3F800000, 32'h35000000);
    send(1, 32'h41123000, 32'h3F800000, 32'h35C00000);
    send(0, 32'h41123001, 32'h3F800000, 32'h35000000);
    send(1, 32'h41123000, 32'h3F800000, 32'hB5000000);
    send(0, 32'h417FFFFF, 32'h3F800000, 32'h35000000);  // carry into exponent
    send(1, 32'hC17FFFFF, 32'h3F800000, 32'hB5000000);
    drain();

    x = rand_fp();
    y = rand_fp();
    send(0, 32'h00000000, x, y);
    send(1, x, 32'h80000000, y);
    send(0, x, y, 32'h00000000);
    send(1, x, 32'h3F800000, {~x.sign, x.exp, x.frac});  // exact cancellation
    send(1, 32'h80000000, 32'h00000000, 32'h80000000);
    send(0, 32'h00000000, 32'h00000000, 32'h80000000);
    drain();

    // port 0 was served last so port 1 must win the first tie
    check_alt = 1'b1;
    fork
      stream(0, 40);
      stream(1, 40);
    join
    drain();
    check_alt = 1'b0;

    $display("errors: %0d wrong values, %0d other failures", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+logic
logic/fma_pkg.sv
logic/fma_issue_arbiter.sv
logic/fma_unpack_align.sv
logic/fma_add_norm.sv
logic/fma_round_pack.sv
logic/fma_top.sv
testbench/fma_tb.sv

// File: run.sh
#!/bin/sh
# build and run the fma testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module fma_tb -f vlog.f -o fma_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/fma_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TESTS PASSED" sim.log; then
  exit 0
fi
exit 1
